// ==== hw/glb_pkg.sv ====
package glb_pkg;

    // bank geometry
    localparam int BANK_DATA_WIDTH     = 64;
    localparam int BANK_STRB_WIDTH     = BANK_DATA_WIDTH / 8;
    localparam int BANK_ADDR_WIDTH     = 8;
    localparam int BYTE_OFFSET_WIDTH   = 3;

    // global address is tile select over bank word over byte offset
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int GLB_ADDR_WIDTH      = TILE_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH
                                         + BYTE_OFFSET_WIDTH;

    // configuration port
    localparam int CFG_ADDR_WIDTH      = 8;
    localparam int CFG_DATA_WIDTH      = 32;
    localparam int CFG_REG_SEL_WIDTH   = 2;
    localparam int CFG_TILE_WIDTH      = CFG_ADDR_WIDTH - CFG_REG_SEL_WIDTH;

    // register indices inside one tile
    localparam int CFG_REG_STRM_START  = 0;
    localparam int CFG_REG_STRM_WORDS  = 1;

    typedef struct packed {
        logic                         wr_en;
        logic [BANK_STRB_WIDTH-1:0]   wr_strb;
        logic [GLB_ADDR_WIDTH-1:0]    wr_addr;
        logic [BANK_DATA_WIDTH-1:0]   wr_data;
    } proc_wr_t;

    typedef struct packed {
        logic                         rd_en;
        logic [GLB_ADDR_WIDTH-1:0]    rd_addr;
    } proc_rd_req_t;

    // shared by processor and cfg responses
    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0]   rd_data;
        logic                         rd_data_valid;
    } rd_rsp_t;

    typedef struct packed {
        logic                         wr_en;
        logic [BANK_STRB_WIDTH-1:0]   wr_strb;
        logic [BANK_ADDR_WIDTH-1:0]   wr_addr;
        logic [BANK_DATA_WIDTH-1:0]   wr_data;
    } bank_wr_t;

    typedef struct packed {
        logic                         rd_en;
        logic [BANK_ADDR_WIDTH-1:0]   rd_addr;
    } bank_rd_t;

    typedef struct packed {
        logic                         wr_en;
        logic [CFG_ADDR_WIDTH-1:0]    wr_addr;
        logic [CFG_DATA_WIDTH-1:0]    wr_data;
    } cfg_wr_t;

    typedef struct packed {
        logic                         rd_en;
        logic [CFG_ADDR_WIDTH-1:0]    rd_addr;
    } cfg_rd_req_t;

    // one bank word toward the fabric
    typedef struct packed {
        logic [BANK_DATA_WIDTH-1:0]   data;
        logic                         valid;
    } strm_word_t;

endpackage

// ==== hw/glb_bank.sv ====
`timescale 1ns/1ps

module glb_bank (
    input  logic                                clk,
    input  logic                                rst_n,

    // processor port
    input  glb_pkg::bank_wr_t                   bank_wr,
    input  glb_pkg::bank_rd_t                   proc_rd,
    output glb_pkg::rd_rsp_t                    proc_rd_rsp,

    // stream port
    input  glb_pkg::bank_rd_t                   strm_rd,
    output logic [glb_pkg::BANK_DATA_WIDTH-1:0] strm_rd_data
);

    import glb_pkg::*;

    localparam int BANK_DEPTH = 2 ** BANK_ADDR_WIDTH;
    localparam int BYTE_WIDTH = BANK_DATA_WIDTH / BANK_STRB_WIDTH;

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];

    logic [BANK_DATA_WIDTH-1:0] proc_rd_data;
    logic                       proc_rd_valid;

    // byte-strobed write
    always_ff @(posedge clk) begin
        if (bank_wr.wr_en) begin
            for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                if (bank_wr.wr_strb[b]) begin
                    mem[bank_wr.wr_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        bank_wr.wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
    end

    // both read ports see the word before a same-edge write
    always_ff @(posedge clk) begin
        if (proc_rd.rd_en) begin
            proc_rd_data <= mem[proc_rd.rd_addr];
        end
        if (strm_rd.rd_en) begin
            strm_rd_data <= mem[strm_rd.rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            proc_rd_valid <= 1'b0;
        end else begin
            proc_rd_valid <= proc_rd.rd_en;
        end
    end

    assign proc_rd_rsp = '{rd_data: proc_rd_data, rd_data_valid: proc_rd_valid};

endmodule

// ==== hw/glb_proc_switch.sv ====
`timescale 1ns/1ps

module glb_proc_switch #(
    parameter int NUM_GLB_TILES = 4
) (
    input  logic                                  clk,
    input  logic                                  rst_n,

    // processor side
    input  glb_pkg::proc_wr_t                     proc_wr,
    input  glb_pkg::proc_rd_req_t                 proc_rd_req,
    output glb_pkg::rd_rsp_t                      proc_rd_rsp,

    // bank side
    output glb_pkg::bank_wr_t [NUM_GLB_TILES-1:0] bank_wr,
    output glb_pkg::bank_rd_t [NUM_GLB_TILES-1:0] bank_rd,
    input  glb_pkg::rd_rsp_t  [NUM_GLB_TILES-1:0] bank_rd_rsp
);

    import glb_pkg::*;

    logic [TILE_SEL_ADDR_WIDTH-1:0] wr_tile;
    logic [TILE_SEL_ADDR_WIDTH-1:0] rd_tile;

    // first stage of the outstanding read
    logic                           rd_pend_valid;
    logic [TILE_SEL_ADDR_WIDTH-1:0] rd_pend_tile;

    // second stage, the registered response
    logic [BANK_DATA_WIDTH-1:0]     rsp_mux;
    logic [BANK_DATA_WIDTH-1:0]     rsp_data;
    logic                           rsp_valid;

    assign wr_tile = proc_wr.wr_addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
    assign rd_tile = proc_rd_req.rd_addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];

    // steer enables, tiles past the build get nothing
    always_comb begin
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            bank_wr[t].wr_en   = proc_wr.wr_en && (wr_tile == TILE_SEL_ADDR_WIDTH'(t));
            bank_wr[t].wr_strb = proc_wr.wr_strb;
            bank_wr[t].wr_addr = proc_wr.wr_addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH];
            bank_wr[t].wr_data = proc_wr.wr_data;

            bank_rd[t].rd_en   = proc_rd_req.rd_en && (rd_tile == TILE_SEL_ADDR_WIDTH'(t));
            bank_rd[t].rd_addr = proc_rd_req.rd_addr[BYTE_OFFSET_WIDTH +: BANK_ADDR_WIDTH];
        end
    end

    // zero unless the recorded tile answered
    always_comb begin
        rsp_mux = '0;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            if (bank_rd_rsp[t].rd_data_valid
                && (rd_pend_tile == TILE_SEL_ADDR_WIDTH'(t))) begin
                rsp_mux = bank_rd_rsp[t].rd_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_pend_valid <= 1'b0;
            rsp_valid     <= 1'b0;
        end else begin
            rd_pend_valid <= proc_rd_req.rd_en;
            rsp_valid     <= rd_pend_valid;
        end
    end

    always_ff @(posedge clk) begin
        rd_pend_tile <= rd_tile;
        rsp_data     <= rsp_mux;
    end

    assign proc_rd_rsp = '{rd_data: rsp_data, rd_data_valid: rsp_valid};

endmodule

// ==== hw/glb_strm_ctrl.sv ====
`timescale 1ns/1ps

module glb_strm_ctrl #(
    parameter int NUM_GLB_TILES = 4
) (
    input  logic                                                 clk,
    input  logic                                                 rst_n,

    // configuration port
    input  glb_pkg::cfg_wr_t                                     if_cfg_wr,
    input  glb_pkg::cfg_rd_req_t                                 if_cfg_rd_req,
    output glb_pkg::rd_rsp_t                                     if_cfg_rd_rsp,

    // control pulses
    input  logic [NUM_GLB_TILES-1:0]                             strm_start_pulse,
    output logic [NUM_GLB_TILES-1:0]                             strm_g2f_interrupt_pulse,

    // bank stream ports
    output glb_pkg::bank_rd_t [NUM_GLB_TILES-1:0]                strm_rd,
    input  logic [NUM_GLB_TILES-1:0][glb_pkg::BANK_DATA_WIDTH-1:0] strm_rd_data,

    // toward the fabric
    output glb_pkg::strm_word_t [NUM_GLB_TILES-1:0]              stream_g2f
);

    import glb_pkg::*;

    // per-tile registers
    logic [NUM_GLB_TILES-1:0][CFG_DATA_WIDTH-1:0] cfg_strm_start;
    logic [NUM_GLB_TILES-1:0][CFG_DATA_WIDTH-1:0] cfg_strm_words;

    // cfg address split
    logic [CFG_TILE_WIDTH-1:0]    wr_tile;
    logic [CFG_REG_SEL_WIDTH-1:0] wr_reg;
    logic [CFG_TILE_WIDTH-1:0]    rd_tile;
    logic [CFG_REG_SEL_WIDTH-1:0] rd_reg;

    // read response
    logic [CFG_DATA_WIDTH-1:0]    rd_word;
    logic [CFG_DATA_WIDTH-1:0]    cfg_rd_data;
    logic                         cfg_rd_valid;

    assign wr_tile = if_cfg_wr.wr_addr[CFG_ADDR_WIDTH-1:CFG_REG_SEL_WIDTH];
    assign wr_reg  = if_cfg_wr.wr_addr[CFG_REG_SEL_WIDTH-1:0];
    assign rd_tile = if_cfg_rd_req.rd_addr[CFG_ADDR_WIDTH-1:CFG_REG_SEL_WIDTH];
    assign rd_reg  = if_cfg_rd_req.rd_addr[CFG_REG_SEL_WIDTH-1:0];

    // register writes to tiles beyond the build are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_strm_start <= '0;
            cfg_strm_words <= '0;
        end else if (if_cfg_wr.wr_en) begin
            for (int t = 0; t < NUM_GLB_TILES; t++) begin
                if (wr_tile == CFG_TILE_WIDTH'(t)) begin
                    if (wr_reg == CFG_REG_SEL_WIDTH'(CFG_REG_STRM_START)) begin
                        cfg_strm_start[t] <= if_cfg_wr.wr_data;
                    end
                    if (wr_reg == CFG_REG_SEL_WIDTH'(CFG_REG_STRM_WORDS)) begin
                        cfg_strm_words[t] <= if_cfg_wr.wr_data;
                    end
                end
            end
        end
    end

    // unmapped register or tile reads zero
    always_comb begin
        rd_word = '0;
        for (int t = 0; t < NUM_GLB_TILES; t++) begin
            if (rd_tile == CFG_TILE_WIDTH'(t)) begin
                if (rd_reg == CFG_REG_SEL_WIDTH'(CFG_REG_STRM_START)) begin
                    rd_word = cfg_strm_start[t];
                end else if (rd_reg == CFG_REG_SEL_WIDTH'(CFG_REG_STRM_WORDS)) begin
                    rd_word = cfg_strm_words[t];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg_rd_valid <= 1'b0;
        end else begin
            cfg_rd_valid <= if_cfg_rd_req.rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (if_cfg_rd_req.rd_en) begin
            cfg_rd_data <= rd_word;
        end
    end

    assign if_cfg_rd_rsp = '{rd_data:       BANK_DATA_WIDTH'(cfg_rd_data),
                             rd_data_valid: cfg_rd_valid};

    // one address sequencer per tile
    for (genvar t = 0; t < NUM_GLB_TILES; t++) begin : g_seq
        logic                       strm_active;
        logic [BANK_ADDR_WIDTH-1:0] strm_addr;
        logic [CFG_DATA_WIDTH-1:0]  strm_left;
        logic                       strm_kick;
        logic                       strm_last;
        logic                       issue_d;
        logic                       last_d;
        logic                       irq;

        // a pulse while words are still going out or with zero words does nothing
        assign strm_kick = strm_start_pulse[t] && !strm_active && !issue_d
                           && (cfg_strm_words[t] != '0);
        assign strm_last = strm_active && (strm_left == CFG_DATA_WIDTH'(1));

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                strm_active <= 1'b0;
                strm_left   <= '0;
                issue_d     <= 1'b0;
                last_d      <= 1'b0;
                irq         <= 1'b0;
            end else begin
                // bank latency is one cycle
                issue_d <= strm_active;
                last_d  <= strm_last;
                irq     <= last_d;
                if (strm_kick) begin
                    strm_active <= 1'b1;
                    strm_left   <= cfg_strm_words[t];
                end else if (strm_active) begin
                    strm_left <= strm_left - 1'b1;
                    if (strm_last) begin
                        strm_active <= 1'b0;
                    end
                end
            end
        end

        // word address wraps at the end of the bank
        always_ff @(posedge clk) begin
            if (strm_kick) begin
                strm_addr <= cfg_strm_start[t][BANK_ADDR_WIDTH-1:0];
            end else if (strm_active) begin
                strm_addr <= strm_addr + 1'b1;
            end
        end

        assign strm_rd[t]    = '{rd_en: strm_active, rd_addr: strm_addr};
        assign stream_g2f[t] = '{data: strm_rd_data[t], valid: issue_d};
        assign strm_g2f_interrupt_pulse[t] = irq;
    end

endmodule

// ==== hw/global_buffer.sv ====
`timescale 1ns/1ps

module global_buffer #(
    parameter int NUM_GLB_TILES = 4
) (
    input  logic                                            clk,
    input  logic                                            rst_n,

    // processor
    input  glb_pkg::proc_wr_t                               proc_wr,
    input  glb_pkg::proc_rd_req_t                           proc_rd_req,
    output glb_pkg::rd_rsp_t                                proc_rd_rsp,

    // configuration
    input  glb_pkg::cfg_wr_t                                if_cfg_wr,
    input  glb_pkg::cfg_rd_req_t                            if_cfg_rd_req,
    output glb_pkg::rd_rsp_t                                if_cfg_rd_rsp,

    // control pulses
    input  logic [NUM_GLB_TILES-1:0]                        strm_start_pulse,
    output logic [NUM_GLB_TILES-1:0]                        strm_g2f_interrupt_pulse,

    // glb to fabric streams
    output glb_pkg::strm_word_t [NUM_GLB_TILES-1:0]         stream_g2f
);

    import glb_pkg::*;

    // processor side of each bank
    bank_wr_t [NUM_GLB_TILES-1:0]                      bank_wr;
    bank_rd_t [NUM_GLB_TILES-1:0]                      bank_rd;
    rd_rsp_t  [NUM_GLB_TILES-1:0]                      bank_rd_rsp;

    // stream side of each bank
    bank_rd_t [NUM_GLB_TILES-1:0]                      strm_rd;
    logic     [NUM_GLB_TILES-1:0][BANK_DATA_WIDTH-1:0] strm_rd_data;

    glb_proc_switch #(
        .NUM_GLB_TILES (NUM_GLB_TILES)
    ) glb_proc_switch (
        .clk         (clk),
        .rst_n       (rst_n),
        .proc_wr     (proc_wr),
        .proc_rd_req (proc_rd_req),
        .proc_rd_rsp (proc_rd_rsp),
        .bank_wr     (bank_wr),
        .bank_rd     (bank_rd),
        .bank_rd_rsp (bank_rd_rsp)
    );

    glb_strm_ctrl #(
        .NUM_GLB_TILES (NUM_GLB_TILES)
    ) glb_strm_ctrl (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .if_cfg_wr                (if_cfg_wr),
        .if_cfg_rd_req            (if_cfg_rd_req),
        .if_cfg_rd_rsp            (if_cfg_rd_rsp),
        .strm_start_pulse         (strm_start_pulse),
        .strm_g2f_interrupt_pulse (strm_g2f_interrupt_pulse),
        .strm_rd                  (strm_rd),
        .strm_rd_data             (strm_rd_data),
        .stream_g2f               (stream_g2f)
    );

    // one bank per tile
    for (genvar t = 0; t < NUM_GLB_TILES; t++) begin : g_tile
        glb_bank glb_bank (
            .clk          (clk),
            .rst_n        (rst_n),
            .bank_wr      (bank_wr[t]),
            .proc_rd      (bank_rd[t]),
            .proc_rd_rsp  (bank_rd_rsp[t]),
            .strm_rd      (strm_rd[t]),
            .strm_rd_data (strm_rd_data[t])
        );
    end

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter realtime PERIOD       = 8.0,
    parameter int      RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release 1 ns after the edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/global_buffer_assert.sv ====
`timescale 1ns/1ps

module global_buffer_assert #(
    parameter int NUM_GLB_TILES = 4
) (
    input logic                                    clk,
    input logic                                    rst_n,
    input glb_pkg::proc_rd_req_t                   proc_rd_req,
    input glb_pkg::rd_rsp_t                        proc_rd_rsp,
    input glb_pkg::cfg_rd_req_t                    if_cfg_rd_req,
    input glb_pkg::rd_rsp_t                        if_cfg_rd_rsp,
    input logic [NUM_GLB_TILES-1:0]                strm_g2f_interrupt_pulse,
    input glb_pkg::strm_word_t [NUM_GLB_TILES-1:0] stream_g2f
);

    import glb_pkg::*;

    proc_rd_lat: assert property (@(posedge clk) disable iff (!rst_n)
        proc_rd_req.rd_en |-> ##2 proc_rd_rsp.rd_data_valid)
        else $error("processor read valid missing 2 cycles after rd_en");

    // no valid without a request two cycles back
    proc_rd_only: assert property (@(posedge clk) disable iff (!rst_n)
        proc_rd_rsp.rd_data_valid |-> $past(proc_rd_req.rd_en, 2))
        else $error("processor read valid without a request");

    cfg_rd_lat: assert property (@(posedge clk) disable iff (!rst_n)
        if_cfg_rd_req.rd_en |-> ##1 if_cfg_rd_rsp.rd_data_valid)
        else $error("cfg read valid missing 1 cycle after rd_en");

    in_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (!proc_rd_rsp.rd_data_valid
            && !if_cfg_rd_rsp.rd_data_valid && (strm_g2f_interrupt_pulse == '0)))
        else $error("valid or interrupt high during reset");

    for (genvar t = 0; t < NUM_GLB_TILES; t++) begin : g_tile
        irq_width: assert property (@(posedge clk) disable iff (!rst_n)
            strm_g2f_interrupt_pulse[t] |=> !strm_g2f_interrupt_pulse[t])
            else $error("interrupt of tile %0d wider than one cycle", t);

        strm_reset: assert property (@(posedge clk)
            (!rst_n && $past(!rst_n)) |-> !stream_g2f[t].valid)
            else $error("stream valid of tile %0d high during reset", t);
    end

endmodule

bind global_buffer global_buffer_assert #(
    .NUM_GLB_TILES (NUM_GLB_TILES)
) global_buffer_assert (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .proc_rd_req              (proc_rd_req),
    .proc_rd_rsp              (proc_rd_rsp),
    .if_cfg_rd_req            (if_cfg_rd_req),
    .if_cfg_rd_rsp            (if_cfg_rd_rsp),
    .strm_g2f_interrupt_pulse (strm_g2f_interrupt_pulse),
    .stream_g2f               (stream_g2f)
);

// ==== tests/tb_global_buffer.sv ====
`timescale 1ns/1ps

module tb_global_buffer;

    import glb_pkg::*;

    localparam int TILES   = 4;
    localparam int TILES_3 = 3;
    localparam int TIMEOUT = 20;

    typedef enum {OP_WR, OP_RD, OP_CFG_WR, OP_CFG_RD, OP_STRM, OP_BURST} op_kind_e;

    // data_lfsr selects lfsr data over the fixed data field
    typedef struct {
        op_kind_e    kind;
        int          addr;
        logic [7:0]  strb;
        bit          data_lfsr;
        logic [63:0] data;
    } op_row_t;

    logic clk;
    logic rst_n;

    proc_wr_t                  proc_wr;
    proc_rd_req_t              proc_rd_req;
    cfg_wr_t                   cfg_wr;
    cfg_rd_req_t               cfg_rd_req;
    logic [TILES-1:0]          start_pulse;
    rd_rsp_t                   proc_rd_rsp;
    rd_rsp_t                   cfg_rd_rsp;
    logic [TILES-1:0]          irq;
    strm_word_t [TILES-1:0]    strm;

    // reduced build sees the same stimulus
    rd_rsp_t                   proc_rd_rsp_3;
    rd_rsp_t                   cfg_rd_rsp_3;
    logic [TILES_3-1:0]        irq_3;
    strm_word_t [TILES_3-1:0]  strm_3;

    logic [63:0] ref_mem [TILES][256];
    logic [31:0] ref_cfg [TILES][2];
    logic [31:0] lfsr_state;
    int          last_addr [TILES];
    op_row_t     table_q [$];

    tb_clk_gen #(.PERIOD(8.0), .RESET_CYCLES(3)) clk_gen (.clk(clk), .rst_n(rst_n));

    global_buffer #(.NUM_GLB_TILES(TILES)) UUT (
        .clk (clk), .rst_n (rst_n),
        .proc_wr (proc_wr), .proc_rd_req (proc_rd_req), .proc_rd_rsp (proc_rd_rsp),
        .if_cfg_wr (cfg_wr), .if_cfg_rd_req (cfg_rd_req), .if_cfg_rd_rsp (cfg_rd_rsp),
        .strm_start_pulse (start_pulse), .strm_g2f_interrupt_pulse (irq),
        .stream_g2f (strm)
    );

    global_buffer #(.NUM_GLB_TILES(TILES_3)) UUT_3 (
        .clk (clk), .rst_n (rst_n),
        .proc_wr (proc_wr), .proc_rd_req (proc_rd_req), .proc_rd_rsp (proc_rd_rsp_3),
        .if_cfg_wr (cfg_wr), .if_cfg_rd_req (cfg_rd_req), .if_cfg_rd_rsp (cfg_rd_rsp_3),
        .strm_start_pulse (start_pulse[TILES_3-1:0]), .strm_g2f_interrupt_pulse (irq_3),
        .stream_g2f (strm_3)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] lfsr_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(string what);
        $display("TIMEOUT at t=%0t: no response while waiting for %s", $time, what);
        $display("Something failed");
        $fatal(1, "wait timed out");
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_quiet();
        for (int t = 0; t < TILES; t++) begin
            check_value($sformatf("stream_g2f[%0d].valid", t), strm[t].valid, 0);
            check_value($sformatf("strm_g2f_interrupt_pulse[%0d]", t), irq[t], 0);
        end
        for (int t = 0; t < TILES_3; t++) begin
            check_value($sformatf("UUT_3 stream_g2f[%0d].valid", t), strm_3[t].valid, 0);
            check_value($sformatf("UUT_3 interrupt[%0d]", t), irq_3[t], 0);
        end
    endtask

    function automatic logic [63:0] model_read(int addr, int n_tiles);
        int tile;
        tile = (addr >> 11) & 3;
        return (tile < n_tiles) ? ref_mem[tile][(addr >> 3) & 255] : 64'h0;
    endfunction

    function automatic logic [63:0] model_cfg(int addr, int n_tiles);
        int tile;
        int rsel;
        tile = addr >> 2;
        rsel = addr & 3;
        return (tile < n_tiles && rsel < 2) ? 64'(ref_cfg[tile][rsel]) : 64'h0;
    endfunction

    task automatic do_write(int addr, logic [7:0] strb, logic [63:0] data);
        int tile;
        int word;
        tile = (addr >> 11) & 3;
        word = (addr >> 3) & 255;
        proc_wr = '{wr_en: 1'b1, wr_strb: strb, wr_addr: GLB_ADDR_WIDTH'(addr), wr_data: data};
        step();
        proc_wr.wr_en = 1'b0;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                ref_mem[tile][word][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        if (strb == 8'hff) begin
            last_addr[tile] = addr;
        end
    endtask

    task automatic do_read(int addr);
        int cycles;
        proc_rd_req = '{rd_en: 1'b1, rd_addr: GLB_ADDR_WIDTH'(addr)};
        step();
        proc_rd_req.rd_en = 1'b0;
        cycles = 1;
        while (!proc_rd_rsp.rd_data_valid) begin
            if (cycles >= TIMEOUT) begin
                timeout_fail("proc_rd_rsp.rd_data_valid");
            end
            step();
            cycles++;
        end
        check_value("proc read latency", cycles, 2);
        check_value("proc_rd_rsp.rd_data", proc_rd_rsp.rd_data, model_read(addr, TILES));
        check_value("UUT_3 proc_rd_rsp.rd_data_valid", proc_rd_rsp_3.rd_data_valid, 1);
        check_value("UUT_3 proc_rd_rsp.rd_data", proc_rd_rsp_3.rd_data,
                    model_read(addr, TILES_3));
    endtask

    // one read per cycle to every tile with responses two cycles behind
    task automatic do_burst();
        for (int c = 0; c <= TILES; c++) begin
            proc_rd_req.rd_en   = (c < TILES);
            proc_rd_req.rd_addr = (c < TILES) ? GLB_ADDR_WIDTH'(last_addr[c]) : '0;
            step();
            check_value("proc_rd_rsp.rd_data_valid", proc_rd_rsp.rd_data_valid, c >= 1);
            check_value("UUT_3 proc_rd_rsp.rd_data_valid", proc_rd_rsp_3.rd_data_valid,
                        c >= 1);
            if (c >= 1) begin
                check_value("proc_rd_rsp.rd_data", proc_rd_rsp.rd_data,
                            model_read(last_addr[c-1], TILES));
                check_value("UUT_3 proc_rd_rsp.rd_data", proc_rd_rsp_3.rd_data,
                            model_read(last_addr[c-1], TILES_3));
            end
        end
        step();
        check_value("proc_rd_rsp.rd_data_valid", proc_rd_rsp.rd_data_valid, 0);
    endtask

    task automatic cfg_write(int addr, logic [31:0] data);
        cfg_wr = '{wr_en: 1'b1, wr_addr: CFG_ADDR_WIDTH'(addr), wr_data: data};
        step();
        cfg_wr.wr_en = 1'b0;
        if ((addr >> 2) < TILES && (addr & 3) < 2) begin
            ref_cfg[addr >> 2][addr & 3] = data;
        end
    endtask

    task automatic cfg_read(int addr);
        int cycles;
        cfg_rd_req = '{rd_en: 1'b1, rd_addr: CFG_ADDR_WIDTH'(addr)};
        step();
        cfg_rd_req.rd_en = 1'b0;
        cycles = 1;
        while (!cfg_rd_rsp.rd_data_valid) begin
            if (cycles >= TIMEOUT) begin
                timeout_fail("if_cfg_rd_rsp.rd_data_valid");
            end
            step();
            cycles++;
        end
        check_value("cfg read latency", cycles, 1);
        check_value("if_cfg_rd_rsp.rd_data", cfg_rd_rsp.rd_data, model_cfg(addr, TILES));
        check_value("UUT_3 if_cfg_rd_rsp.rd_data_valid", cfg_rd_rsp_3.rd_data_valid, 1);
        check_value("UUT_3 if_cfg_rd_rsp.rd_data", cfg_rd_rsp_3.rd_data,
                    model_cfg(addr, TILES_3));
    endtask

    task automatic check_others(int tile);
        for (int t = 0; t < TILES; t++) begin
            if (t != tile) begin
                check_value($sformatf("stream_g2f[%0d].valid", t), strm[t].valid, 0);
            end
        end
    endtask

    task automatic do_stream(int tile);
        int          cycles;
        int          words;
        logic [63:0] exp;
        words = ref_cfg[tile][1];
        start_pulse[tile] = 1'b1;
        step();
        start_pulse = '0;
        if (words == 0) begin
            // zero count stays silent
            repeat (6) begin
                check_quiet();
                step();
            end
        end else begin
            cycles = 1;
            while (!strm[tile].valid) begin
                if (cycles >= TIMEOUT) begin
                    timeout_fail($sformatf("stream_g2f[%0d].valid", tile));
                end
                check_others(tile);
                step();
                cycles++;
            end
            check_value("stream first word latency", cycles, 2);
            for (int i = 0; i < words; i++) begin
                exp = ref_mem[tile][(ref_cfg[tile][0] + i) & 255];
                check_value($sformatf("stream_g2f[%0d].valid", tile), strm[tile].valid, 1);
                check_value($sformatf("stream_g2f[%0d].data", tile), strm[tile].data, exp);
                check_value($sformatf("strm_g2f_interrupt_pulse[%0d]", tile), irq[tile], 0);
                if (tile < TILES_3) begin
                    check_value("UUT_3 stream data", strm_3[tile].data, exp);
                    check_value("UUT_3 stream valid", strm_3[tile].valid, 1);
                end
                check_others(tile);
                // restart attempt in the middle of the stream
                start_pulse[tile] = (i == 0);
                step();
            end
            start_pulse = '0;
            check_value($sformatf("stream_g2f[%0d].valid", tile), strm[tile].valid, 0);
            check_value($sformatf("strm_g2f_interrupt_pulse[%0d]", tile), irq[tile], 1);
            if (tile < TILES_3) begin
                check_value("UUT_3 stream valid", strm_3[tile].valid, 0);
                check_value("UUT_3 interrupt", irq_3[tile], 1);
            end
            step();
            check_quiet();
        end
    endtask

    task automatic build_table();
        int          addr;
        int          start_w [TILES];
        int          count_w [TILES];
        start_w = '{20, 254, 100, 7};
        count_w = '{4, 5, 1, 0};
        for (int a = 0; a < 24; a++) begin
            if ((a & 3) != 3) begin
                table_q.push_back('{OP_CFG_RD, a, 8'h0, 0, 64'h0});
            end
        end
        for (int t = 0; t < TILES; t++) begin
            for (int k = 0; k < 2; k++) begin
                addr = (t << 11) | (int'(lfsr_bits(8)) << 3);
                table_q.push_back('{OP_WR, addr, 8'hff, 1, 64'h0});
                table_q.push_back('{OP_WR, addr, 8'(lfsr_bits(8)), 1, 64'h0});
                table_q.push_back('{OP_RD, addr, 8'h0, 0, 64'h0});
            end
        end
        table_q.push_back('{OP_BURST, 0, 8'h0, 0, 64'h0});
        for (int t = 0; t < TILES; t++) begin
            table_q.push_back('{OP_CFG_WR, t * 4, 8'h0, 0, 64'(start_w[t])});
            table_q.push_back('{OP_CFG_WR, t * 4 + 1, 8'h0, 0, 64'(count_w[t])});
            table_q.push_back('{OP_CFG_RD, t * 4, 8'h0, 0, 64'h0});
            table_q.push_back('{OP_CFG_RD, t * 4 + 1, 8'h0, 0, 64'h0});
            for (int i = 0; i < count_w[t]; i++) begin
                addr = (t << 11) | (((start_w[t] + i) & 255) << 3);
                table_q.push_back('{OP_WR, addr, 8'hff, 1, 64'h0});
            end
        end
        for (int t = 0; t < TILES; t++) begin
            table_q.push_back('{OP_STRM, t, 8'h0, 0, 64'h0});
        end
    endtask

    task automatic apply_row(op_row_t row);
        logic [63:0] data;
        data = row.data_lfsr ? lfsr_bits(64) : row.data;
        case (row.kind)
            OP_WR:     do_write(row.addr, row.strb, data);
            OP_RD:     do_read(row.addr);
            OP_CFG_WR: cfg_write(row.addr, data[31:0]);
            OP_CFG_RD: cfg_read(row.addr);
            OP_STRM:   do_stream(row.addr);
            default:   do_burst();
        endcase
    endtask

    initial begin
        int cycles;
        proc_wr     = '0;
        proc_rd_req = '0;
        cfg_wr      = '0;
        cfg_rd_req  = '0;
        start_pulse = '0;
        lfsr_state  = 32'had85_1d80;
        for (int t = 0; t < TILES; t++) begin
            ref_cfg[t][0] = '0;
            ref_cfg[t][1] = '0;
            last_addr[t]  = 0;
        end
        build_table();

        cycles = 0;
        while (!rst_n) begin
            if (cycles >= TIMEOUT) begin
                timeout_fail("reset release");
            end
            step();
            cycles++;
        end

        // idle outputs before any request
        repeat (4) begin
            check_value("proc_rd_rsp.rd_data_valid", proc_rd_rsp.rd_data_valid, 0);
            check_value("if_cfg_rd_rsp.rd_data_valid", cfg_rd_rsp.rd_data_valid, 0);
            check_value("UUT_3 proc_rd_rsp.rd_data_valid", proc_rd_rsp_3.rd_data_valid, 0);
            check_value("UUT_3 if_cfg_rd_rsp.rd_data_valid", cfg_rd_rsp_3.rd_data_valid, 0);
            check_quiet();
            step();
        end

        foreach (table_q[i]) begin
            apply_row(table_q[i]);
        end

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src.f ====
hw/glb_pkg.sv
hw/glb_bank.sv
hw/glb_proc_switch.sv
hw/glb_strm_ctrl.sv
hw/global_buffer.sv
tests/tb_clk_gen.sv
tests/global_buffer_assert.sv
tests/tb_global_buffer.sv

// ==== Bender.yml ====
package:
  name: global_buffer

sources:
  - hw/glb_pkg.sv
  - hw/glb_bank.sv
  - hw/glb_proc_switch.sv
  - hw/glb_strm_ctrl.sv
  - hw/global_buffer.sv
  - target: test
    files:
      - tests/tb_clk_gen.sv
      - tests/global_buffer_assert.sv
      - tests/tb_global_buffer.sv
